/* avmm_cmd_path.f */
src/avmm_cmd_pkg.sv
src/avmm_cmd_deframer.sv
src/avmm_cmd_checker.sv
src/avmm_cmd_dispatch.sv
src/avmm_cmd_path.sv
verif/avmm_cmd_path_assertions.sv
verif/tb_avmm_cmd_path.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --assert --timescale 1ns/1ps
TOP = tb_avmm_cmd_path
FILELIST = avmm_cmd_path.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_avmm_cmd_path.sv */
// random AVMM command frames in pld and hard-IP mode, checked against a model
// of the framing and packing rules; leaves load_hold + 3 idle symbols between frames
`timescale 1ns/1ps

module tb_avmm_cmd_path;
	import avmm_cmd_pkg::*;

	localparam int load_hold = 8;
	localparam int pld_frames = 40;
	localparam int hip_frames = 40;
	localparam int frame_cycles = cmd_symbols + load_hold + 4;
	localparam int watchdog_cycles = (pld_frames + hip_frames + 2) * frame_cycles + 200;
	localparam logic [31:0] lfsr_seed = 32'hb425_6371;

	logic					avmm_clock_rx_osc_clk;
	logic					avmm_reset_rx_osc_clk_rst_n;
	logic [1:0]				avmm_data_in;
	logic					hip_sel;
	logic					pld_avmm_read;
	logic					pld_avmm_write;
	logic					pld_avmm_request;
	logic [9:0]				pld_avmm_reg_addr;
	logic [8:0]				pld_avmm_reserved_out;
	logic [7:0]				pld_avmm_writedata;
	logic [hip_bus_width-1:0]		hip_avmm_in;
	logic					dcg_ungate;
	logic					cmd_error;
	logic [8:0]				cmd_testbus;

	logic [31:0]	lfsr;
	logic		exp_error;
	logic		exp_req;
	int		checks = 0;
	int		errors = 0;

	avmm_cmd_path #(.load_hold(load_hold)) i_dut (.*);

	bind avmm_cmd_path avmm_cmd_path_assertions #(.load_hold(load_hold)) i_assertions (
		.avmm_clock_rx_osc_clk(avmm_clock_rx_osc_clk),
		.avmm_reset_rx_osc_clk_rst_n(avmm_reset_rx_osc_clk_rst_n),
		.pld_avmm_read(pld_avmm_read),
		.pld_avmm_write(pld_avmm_write),
		.pld_avmm_reg_addr(pld_avmm_reg_addr),
		.pld_avmm_reserved_out(pld_avmm_reserved_out),
		.pld_avmm_writedata(pld_avmm_writedata),
		.hip_avmm_in(hip_avmm_in),
		.dcg_ungate(dcg_ungate),
		.cmd_error(cmd_error)
	);

	initial
	begin
		avmm_clock_rx_osc_clk = 1'b0;
		forever #2 avmm_clock_rx_osc_clk = ~avmm_clock_rx_osc_clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'hd000_0001) : (state >> 1);
	endfunction

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr = lfsr_step(lfsr);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	// start bit set and even parity over the other 31 bits
	function automatic logic [31:0] make_pld_word();
		logic [31:0] w;
		w = random_bits(32);
		w[0] = 1'b1;
		w[23] = ^{w[31:24], w[22:0]};
		return w;
	endfunction

	function automatic logic [31:0] make_hip_word();
		logic [31:0] w;
		w = random_bits(32);
		w[0] = 1'b1;
		w[2] = w[2] || !w[3];
		return w;
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		assert (got === want)
		else
		begin
			$display("Error: %s got %h expected %h", name, got, want);
			errors++;
		end
	endtask

	task automatic check_outputs(input logic [31:0] w, input logic active);
		logic pld_on;
		logic hip_on;
		pld_on = active && !hip_sel;
		hip_on = active && hip_sel;
		compare("pld_avmm_read", 32'(pld_avmm_read), 32'(pld_on && w[3]));
		compare("pld_avmm_write", 32'(pld_avmm_write), 32'(pld_on && w[1]));
		compare("pld_avmm_request", 32'(pld_avmm_request), 32'(exp_req));
		compare("pld_avmm_reg_addr", 32'(pld_avmm_reg_addr), pld_on ? 32'(w[13:4]) : 32'd0);
		compare("pld_avmm_reserved_out", 32'(pld_avmm_reserved_out),
			pld_on ? 32'(w[22:14]) : 32'd0);
		compare("pld_avmm_writedata", 32'(pld_avmm_writedata), pld_on ? 32'(w[31:24]) : 32'd0);
		compare("hip_avmm_in", 32'(hip_avmm_in),
			hip_on ? 32'({w[3], w[2], w[1], w[23:4], w[31:24]}) : 32'd0);
		compare("dcg_ungate", 32'(dcg_ungate), 32'(active));
		compare("cmd_error", 32'(cmd_error), 32'(exp_error));
	endtask

	task automatic apply_reset(input logic hip_mode);
		avmm_reset_rx_osc_clk_rst_n <= 1'b0;
		avmm_data_in <= 2'b00;
		hip_sel <= hip_mode;
		repeat (4) @(posedge avmm_clock_rx_osc_clk);
		@(negedge avmm_clock_rx_osc_clk);
		compare("pld_avmm_reg_addr", 32'(pld_avmm_reg_addr), 32'h3ff);
		compare("pld_avmm_reserved_out", 32'(pld_avmm_reserved_out), 32'h1ff);
		compare("pld_avmm_writedata", 32'(pld_avmm_writedata), 32'hff);
		compare("pld_avmm_read", 32'(pld_avmm_read), 32'd0);
		compare("pld_avmm_write", 32'(pld_avmm_write), 32'd0);
		compare("pld_avmm_request", 32'(pld_avmm_request), 32'd0);
		compare("hip_avmm_in", 32'(hip_avmm_in), 32'd0);
		compare("dcg_ungate", 32'(dcg_ungate), 32'd0);
		compare("cmd_error", 32'(cmd_error), 32'd0);
		@(posedge avmm_clock_rx_osc_clk);
		avmm_reset_rx_osc_clk_rst_n <= 1'b1;
		exp_error = 1'b0;
		exp_req = 1'b0;
	endtask

	// the word goes out lowest symbol first and its fields appear three edges after the last one
	task automatic run_frame(input logic [31:0] word, input logic fault);
		for (int i = 0; i < cmd_symbols; i++)
		begin
			@(posedge avmm_clock_rx_osc_clk);
			avmm_data_in <= word[2*i +: 2];
			@(negedge avmm_clock_rx_osc_clk);
			// symbol i - 1 sits in the symbol register with the count enable set
			compare("cmd_testbus", 32'(cmd_testbus),
				(i == 0) ? 32'd0 : {27'd0, 4'(i - 1), 1'b1});
		end
		@(posedge avmm_clock_rx_osc_clk);
		avmm_data_in <= 2'b00;
		repeat (2) @(posedge avmm_clock_rx_osc_clk);
		exp_error = exp_error || fault;
		if (!hip_sel)
		begin
			exp_req = word[2];
		end
		for (int i = 0; i < load_hold; i++)
		begin
			@(negedge avmm_clock_rx_osc_clk);
			check_outputs(word, 1'b1);
			// the hold count and cmd_load lead dcg_ungate by one cycle
			if (i < load_hold - 1)
			begin
				compare("cmd_testbus", 32'(cmd_testbus), {23'd0, 3'(i + 1), 1'b1, 5'd0});
			end
			@(posedge avmm_clock_rx_osc_clk);
		end
		@(negedge avmm_clock_rx_osc_clk);
		check_outputs(word, 1'b0);
	endtask

	task automatic inject_framing_symbol(input logic expect_error);
		@(posedge avmm_clock_rx_osc_clk);
		avmm_data_in <= 2'b10;
		@(posedge avmm_clock_rx_osc_clk);
		avmm_data_in <= 2'b00;
		@(posedge avmm_clock_rx_osc_clk);
		exp_error = expect_error;
		repeat (load_hold)
		begin
			@(negedge avmm_clock_rx_osc_clk);
			check_outputs(32'd0, 1'b0);
			@(posedge avmm_clock_rx_osc_clk);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		avmm_reset_rx_osc_clk_rst_n = 1'b0;
		avmm_data_in = 2'b00;
		hip_sel = 1'b0;
		lfsr = lfsr_seed;
		apply_reset(1'b0);
		repeat (pld_frames)
		begin
			run_frame(make_pld_word(), 1'b0);
		end
		// a flipped parity bit raises the flag until the next reset
		run_frame(make_pld_word() ^ 32'h0080_0000, 1'b1);
		@(posedge avmm_clock_rx_osc_clk);
		apply_reset(1'b0);
		inject_framing_symbol(1'b1);
		@(posedge avmm_clock_rx_osc_clk);
		apply_reset(1'b1);
		inject_framing_symbol(1'b0);
		repeat (hip_frames)
		begin
			run_frame(make_hip_word(), 1'b0);
		end
		// valid bit with neither request nor read
		run_frame((random_bits(32) & 32'hffff_fff3) | 32'h1, 1'b1);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("=== PASS ===");
		end
		else
		begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge avmm_clock_rx_osc_clk);
		$display("timeout, the tests did not finish within %0d cycles", watchdog_cycles);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* verif/avmm_cmd_path_assertions.sv */
// concurrent checks on the command path outputs, bound into avmm_cmd_path
// load_hold must match the value the DUT was built with
`timescale 1ns/1ps

module avmm_cmd_path_assertions
#(
	parameter int load_hold = avmm_cmd_pkg::default_load_hold
)
(
	input	logic					avmm_clock_rx_osc_clk,
	input	logic					avmm_reset_rx_osc_clk_rst_n,
	input	logic					pld_avmm_read,
	input	logic					pld_avmm_write,
	input	logic [9:0]				pld_avmm_reg_addr,
	input	logic [8:0]				pld_avmm_reserved_out,
	input	logic [7:0]				pld_avmm_writedata,
	input	logic [avmm_cmd_pkg::hip_bus_width-1:0]	hip_avmm_in,
	input	logic					dcg_ungate,
	input	logic					cmd_error
);
	logic		pld_busy;
	logic		hip_busy;
	logic [4:0]	ungate_run;

	// request is a held level between commands and says nothing about activity
	assign pld_busy = pld_avmm_read || pld_avmm_write || (|pld_avmm_reg_addr) ||
		(|pld_avmm_reserved_out) || (|pld_avmm_writedata);
	assign hip_busy = |hip_avmm_in;

	always_ff @(posedge avmm_clock_rx_osc_clk)
	begin
		if (!avmm_reset_rx_osc_clk_rst_n)
		begin
			ungate_run <= 5'd0;
		end
		else
		begin
			ungate_run <= dcg_ungate ? ungate_run + 5'd1 : 5'd0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	no_overlap: assert property (@(posedge avmm_clock_rx_osc_clk)
		disable iff (!avmm_reset_rx_osc_clk_rst_n) !(pld_busy && hip_busy))
	else $error("pld and hard-IP outputs are active in the same cycle");

	error_sticky: assert property (@(posedge avmm_clock_rx_osc_clk)
		(avmm_reset_rx_osc_clk_rst_n && $past(avmm_reset_rx_osc_clk_rst_n) &&
		$past(cmd_error)) |-> cmd_error)
	else $error("cmd_error dropped without a reset");

	ungate_length: assert property (@(posedge avmm_clock_rx_osc_clk)
		disable iff (!avmm_reset_rx_osc_clk_rst_n)
		$fell(dcg_ungate) |-> (ungate_run == 5'(load_hold)))
	else $error("dcg_ungate window length differs from load_hold");

endmodule

/* src/avmm_cmd_path.sv */
// AVMM command path, single clock and synchronous reset, no response path
// callers must leave at least load_hold idle symbols between frames
`timescale 1ns/1ps

module avmm_cmd_path
#(
	parameter int load_hold = avmm_cmd_pkg::default_load_hold
)
(
	input	logic					avmm_clock_rx_osc_clk,
	input	logic					avmm_reset_rx_osc_clk_rst_n,
	input	logic [1:0]				avmm_data_in,
	input	logic					hip_sel,
	output	logic					pld_avmm_read,
	output	logic					pld_avmm_write,
	output	logic					pld_avmm_request,
	output	logic [9:0]				pld_avmm_reg_addr,
	output	logic [8:0]				pld_avmm_reserved_out,
	output	logic [7:0]				pld_avmm_writedata,
	output	logic [avmm_cmd_pkg::hip_bus_width-1:0]	hip_avmm_in,
	output	logic					dcg_ungate,
	output	logic					cmd_error,
	output	logic [8:0]				cmd_testbus
);
	import avmm_cmd_pkg::*;

	logic [cmd_word_width-1:0]	cmd_word;
	logic				cmd_load;
	logic				cmd_captured;
	logic				frame_error_pulse;
	logic				hip_valid_error;

	avmm_cmd_deframer #(
		.load_hold(load_hold)
	) i_deframer (
		.avmm_clock_rx_osc_clk(avmm_clock_rx_osc_clk),
		.avmm_reset_rx_osc_clk_rst_n(avmm_reset_rx_osc_clk_rst_n),
		.avmm_data_in(avmm_data_in),
		.cmd_word(cmd_word),
		.cmd_load(cmd_load),
		.cmd_captured(cmd_captured),
		.frame_error_pulse(frame_error_pulse),
		.hip_sel(hip_sel),
		.cmd_testbus(cmd_testbus)
	);

	// checker and dispatch both work on the same captured word
	avmm_cmd_checker i_checker (
		.avmm_clock_rx_osc_clk(avmm_clock_rx_osc_clk),
		.avmm_reset_rx_osc_clk_rst_n(avmm_reset_rx_osc_clk_rst_n),
		.cmd_word(cmd_word),
		.cmd_captured(cmd_captured),
		.hip_sel(hip_sel),
		.frame_error_pulse(frame_error_pulse),
		.hip_valid_error(hip_valid_error),
		.cmd_error(cmd_error)
	);

	avmm_cmd_dispatch i_dispatch (
		.avmm_clock_rx_osc_clk(avmm_clock_rx_osc_clk),
		.avmm_reset_rx_osc_clk_rst_n(avmm_reset_rx_osc_clk_rst_n),
		.cmd_word(cmd_word),
		.cmd_load(cmd_load),
		.hip_sel(hip_sel),
		.pld_avmm_read(pld_avmm_read),
		.pld_avmm_write(pld_avmm_write),
		.pld_avmm_request(pld_avmm_request),
		.pld_avmm_reg_addr(pld_avmm_reg_addr),
		.pld_avmm_reserved_out(pld_avmm_reserved_out),
		.pld_avmm_writedata(pld_avmm_writedata),
		.hip_avmm_in(hip_avmm_in),
		.dcg_ungate(dcg_ungate),
		.hip_valid_error(hip_valid_error)
	);

endmodule

/* src/avmm_cmd_dispatch.sv */
// presents the held command word on the pld register port or the hard-IP bus
// hip_sel is assumed static while commands are in flight
`timescale 1ns/1ps

module avmm_cmd_dispatch
(
	input	logic						avmm_clock_rx_osc_clk,
	input	logic						avmm_reset_rx_osc_clk_rst_n,
	input	logic [avmm_cmd_pkg::cmd_word_width-1:0]	cmd_word,
	input	logic						cmd_load,
	input	logic						hip_sel,
	output	logic						pld_avmm_read,
	output	logic						pld_avmm_write,
	output	logic						pld_avmm_request,
	output	logic [9:0]					pld_avmm_reg_addr,
	output	logic [8:0]					pld_avmm_reserved_out,
	output	logic [7:0]					pld_avmm_writedata,
	output	logic [avmm_cmd_pkg::hip_bus_width-1:0]	hip_avmm_in,
	output	logic						dcg_ungate,
	output	logic						hip_valid_error
);
	import avmm_cmd_pkg::*;

	logic	pld_load;
	logic	hip_load;

	assign pld_load = cmd_load && !hip_sel;
	assign hip_load = cmd_load && hip_sel;

	// first cycle of the load only, dcg_ungate still low from the idle gap
	assign hip_valid_error = hip_load && !dcg_ungate && cmd_word[cmd_bit_valid] &&
		!cmd_word[cmd_bit_request] && !cmd_word[cmd_bit_read];

	always_ff @(posedge avmm_clock_rx_osc_clk)
	begin
		if (!avmm_reset_rx_osc_clk_rst_n)
		begin
			dcg_ungate <= 1'b0;
			pld_avmm_request <= 1'b0;
		end
		else
		begin
			dcg_ungate <= cmd_load;
			// request holds its last value between pld commands
			if (pld_load)
			begin
				pld_avmm_request <= cmd_word[cmd_bit_request];
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pld register port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge avmm_clock_rx_osc_clk)
	begin
		if (!avmm_reset_rx_osc_clk_rst_n)
		begin
			pld_avmm_read <= 1'b0;
			pld_avmm_write <= 1'b0;
			pld_avmm_reg_addr <= '1;
			pld_avmm_reserved_out <= '1;
			pld_avmm_writedata <= '1;
		end
		else if (pld_load)
		begin
			pld_avmm_read <= cmd_word[cmd_bit_read];
			pld_avmm_write <= cmd_word[cmd_bit_write];
			pld_avmm_reg_addr <= cmd_word[cmd_addr_msb:cmd_addr_lsb];
			pld_avmm_reserved_out <= cmd_word[cmd_rsvd_msb:cmd_rsvd_lsb];
			pld_avmm_writedata <= cmd_word[cmd_data_msb:cmd_data_lsb];
		end
		else
		begin
			pld_avmm_read <= 1'b0;
			pld_avmm_write <= 1'b0;
			pld_avmm_reg_addr <= '0;
			pld_avmm_reserved_out <= '0;
			pld_avmm_writedata <= '0;
		end
	end

	// hard-IP packing keeps address, reserved and parity bits together in 27:8
	always_ff @(posedge avmm_clock_rx_osc_clk)
	begin
		if (!avmm_reset_rx_osc_clk_rst_n || !hip_load)
		begin
			hip_avmm_in <= '0;
		end
		else
		begin
			hip_avmm_in <= {cmd_word[cmd_bit_read], cmd_word[cmd_bit_request],
				cmd_word[cmd_bit_write], cmd_word[cmd_parity_bit:cmd_addr_lsb],
				cmd_word[cmd_data_msb:cmd_data_lsb]};
		end
	end

endmodule

/* src/avmm_cmd_checker.sv */
// merges parity, framing and hard-IP validity faults into one sticky flag
// only a reset clears the flag
`timescale 1ns/1ps

module avmm_cmd_checker
(
	input	logic						avmm_clock_rx_osc_clk,
	input	logic						avmm_reset_rx_osc_clk_rst_n,
	input	logic [avmm_cmd_pkg::cmd_word_width-1:0]	cmd_word,
	input	logic						cmd_captured,
	input	logic						hip_sel,
	input	logic						frame_error_pulse,
	input	logic						hip_valid_error,
	output	logic						cmd_error
);
	import avmm_cmd_pkg::*;

	localparam int parity_width = cmd_word_width - 1;

	logic [parity_width-1:0]	parity_data;
	logic				parity_mismatch;
	logic				parity_error;

	// every bit except the parity bit itself
	assign parity_data = {cmd_word[cmd_data_msb:cmd_data_lsb], cmd_word[cmd_parity_bit-1:0]};

	assign parity_mismatch = ((^parity_data) != cmd_word[cmd_parity_bit]);

	// the hard IP checks its own parity, so only pld words count here
	assign parity_error = cmd_captured && !hip_sel && parity_mismatch;

	always_ff @(posedge avmm_clock_rx_osc_clk)
	begin
		if (!avmm_reset_rx_osc_clk_rst_n)
		begin
			cmd_error <= 1'b0;
		end
		else
		begin
			cmd_error <= cmd_error || parity_error || frame_error_pulse || hip_valid_error;
		end
	end

endmodule

/* src/avmm_cmd_deframer.sv */
// frames the 2-bit AIB symbol stream into command words, no back-pressure
// load_hold must lie between 2 and 16; a new word restarts the hold window
`timescale 1ns/1ps

module avmm_cmd_deframer
#(
	parameter int load_hold = avmm_cmd_pkg::default_load_hold
)
(
	input	logic						avmm_clock_rx_osc_clk,
	input	logic						avmm_reset_rx_osc_clk_rst_n,
	input	logic [1:0]					avmm_data_in,
	output	logic [avmm_cmd_pkg::cmd_word_width-1:0]	cmd_word,
	output	logic						cmd_load,
	output	logic						cmd_captured,
	output	logic						frame_error_pulse,
	input	logic						hip_sel,
	output	logic [8:0]					cmd_testbus
);
	import avmm_cmd_pkg::*;

	localparam int hist_width = cmd_word_width - 2;

	logic [1:0]		sym_reg;
	logic [3:0]		sym_cnt;
	logic			cnt_en;
	logic			last_sym;
	logic [hist_width-1:0]	sym_hist;
	logic [3:0]		hold_cnt;

	// a frame opens on a start bit while idle and then runs for all symbols
	assign cnt_en = ((sym_cnt == 4'd0) && sym_reg[0]) || (sym_cnt != 4'd0);
	assign last_sym = (sym_cnt == 4'(cmd_symbols - 1));

	// a lone 10 symbol between frames is not a legal idle in pld mode
	assign frame_error_pulse = ~hip_sel && (sym_reg == 2'b10) && (sym_cnt == 4'd0);

	assign cmd_testbus = {hold_cnt[2:0], cmd_load, sym_cnt, cnt_en};

	always_ff @(posedge avmm_clock_rx_osc_clk)
	begin
		if (!avmm_reset_rx_osc_clk_rst_n)
		begin
			sym_reg <= 2'b00;
			sym_cnt <= 4'd0;
		end
		else
		begin
			sym_reg <= avmm_data_in;
			if (cnt_en)
			begin
				sym_cnt <= sym_cnt + 4'd1;
			end
			else
			begin
				sym_cnt <= 4'd0;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// word assembly
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// newest symbol enters at the top, so the first one ends up in bits 1:0
	always_ff @(posedge avmm_clock_rx_osc_clk)
	begin
		sym_hist <= {sym_reg, sym_hist[hist_width-1:2]};
		if (last_sym)
		begin
			cmd_word <= {sym_reg, sym_hist};
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// load window
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge avmm_clock_rx_osc_clk)
	begin
		if (!avmm_reset_rx_osc_clk_rst_n)
		begin
			cmd_load <= 1'b0;
			cmd_captured <= 1'b0;
			hold_cnt <= 4'd0;
		end
		else
		begin
			cmd_captured <= last_sym;
			cmd_load <= last_sym || (cmd_load && (hold_cnt != 4'(load_hold - 1)));
			if (last_sym || !cmd_load)
			begin
				hold_cnt <= 4'd0;
			end
			else
			begin
				hold_cnt <= hold_cnt + 4'd1;
			end
		end
	end

endmodule

/* src/avmm_cmd_pkg.sv */
// command word layout shared by the AVMM command path
// field positions follow the AIB serial command format and are not configurable
package avmm_cmd_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// word framing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	parameter int cmd_word_width = 32;

	// each symbol carries two bits of the word
	parameter int cmd_symbols = 16;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// field positions
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	parameter int cmd_bit_valid = 0;
	parameter int cmd_bit_write = 1;
	parameter int cmd_bit_request = 2;
	parameter int cmd_bit_read = 3;

	parameter int cmd_addr_lsb = 4;
	parameter int cmd_addr_msb = 13;

	parameter int cmd_rsvd_lsb = 14;
	parameter int cmd_rsvd_msb = 22;

	// even parity over every other bit of the word
	parameter int cmd_parity_bit = 23;

	parameter int cmd_data_lsb = 24;
	parameter int cmd_data_msb = 31;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// downstream
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	parameter int hip_bus_width = 31;

	// cycles that a command stays presented on the output ports
	parameter int default_load_hold = 8;

endpackage
